//--- exu_alu.sv
`default_nettype none
`include "exu_settings.svh"

module exu_alu (
  input  logic                 mdu_busy,
  input  logic [`EXU_XLEN:0]   mdu_src_a,
  input  logic [`EXU_XLEN:0]   mdu_src_b,
  input  logic [`EXU_XLEN-1:0] alu_a,
  input  logic [`EXU_XLEN-1:0] alu_b,
  input  exu_pkg::alu_op_e     alu_op,
  output logic [`EXU_XLEN+1:0] add_res_34,
  output logic [`EXU_XLEN-1:0] add_res_32,
  output logic                 not_zero,
  output logic [`EXU_XLEN-1:0] alu_c
);
  import exu_pkg::*;

  localparam int MSB   = `EXU_XLEN - 1;
  localparam int SHW   = $clog2(`EXU_XLEN);

  function automatic logic [`EXU_XLEN-1:0] reverse_bits(input logic [`EXU_XLEN-1:0] v);
    logic [`EXU_XLEN-1:0] r;
    for (int i = 0; i < `EXU_XLEN; i++) begin
      r[i] = v[MSB-i];
    end
    return r;
  endfunction

  // ####################
  // Shared adder
  logic [`EXU_XLEN:0] b_ext;
  logic [`EXU_XLEN:0] src_a;
  logic [`EXU_XLEN:0] src_b;
  logic               is_sub;

  always_comb begin
    case (alu_op)
      SUB, EQ, NE, LT, LTU, GE, GEU: is_sub = 1'b1;
      default:                       is_sub = 1'b0;
    endcase
  end

  assign b_ext      = {alu_b, 1'b0};
  assign src_a      = mdu_busy ? mdu_src_a : {alu_a, 1'b1};  // Trailing 1 is the +1 of a subtract.
  assign src_b      = mdu_busy ? mdu_src_b : (is_sub ? ~b_ext : b_ext);
  assign add_res_34 = {1'b0, src_a} + {1'b0, src_b};
  assign add_res_32 = add_res_34[`EXU_XLEN:1];
  assign not_zero   = |add_res_32;

  // ####################
  // Compare and shift
  logic                 ovf;
  logic                 lt_res;
  logic [SHW-1:0]       shamt;
  logic [`EXU_XLEN-1:0] shift_in;
  logic [`EXU_XLEN:0]   shift_ext;

  assign ovf    = (alu_a[MSB] != alu_b[MSB]) && (add_res_32[MSB] != alu_a[MSB]);
  assign lt_res = (alu_op == LT || alu_op == GE) ? (add_res_32[MSB] ^ ovf)
                                                 : ~add_res_34[`EXU_XLEN+1];

  assign shamt     = alu_b[SHW-1:0];
  assign shift_in  = (alu_op == SLL) ? reverse_bits(alu_a) : alu_a;  // SLL reuses the right shifter.
  assign shift_ext = $signed({(alu_op == SRA) & shift_in[MSB], shift_in}) >>> shamt;

  always_comb begin
    case (alu_op)
      ADD, SUB: alu_c = add_res_32;
      EQ:       alu_c = {{MSB{1'b0}}, ~not_zero};
      NE:       alu_c = {{MSB{1'b0}}, not_zero};
      LT, LTU:  alu_c = {{MSB{1'b0}}, lt_res};
      GE, GEU:  alu_c = {{MSB{1'b0}}, ~lt_res};
      SLL:      alu_c = reverse_bits(shift_ext[MSB:0]);
      SRL, SRA: alu_c = shift_ext[MSB:0];
      AND:      alu_c = alu_a & alu_b;
      OR:       alu_c = alu_a | alu_b;
      XOR:      alu_c = alu_a ^ alu_b;
      default:  alu_c = add_res_32;
    endcase
  end

endmodule

`default_nettype wire

//--- exu_core.sv
`default_nettype none
`include "exu_settings.svh"

module exu_core (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  head_valid,
  input  exu_pkg::exu_op_u      head_op,
  input  logic [`EXU_XLEN-1:0]  head_a,
  input  logic [`EXU_XLEN-1:0]  head_b,
  input  logic [`EXU_TAG_W-1:0] head_tag,
  input  logic                  res_space,
  output logic                  head_take,
  output logic                  wr_valid,
  output logic [`EXU_TAG_W-1:0] wr_tag,
  output logic [`EXU_XLEN-1:0]  wr_data
);
  import exu_pkg::*;

  logic [`EXU_XLEN-1:0]  alu_a;
  logic [`EXU_XLEN-1:0]  alu_b;
  alu_op_e               alu_op;
  logic [`EXU_XLEN-1:0]  alu_c;
  logic                  mdu_start;
  mdu_op_e               mdu_op;
  logic [`EXU_XLEN-1:0]  mdu_a;
  logic [`EXU_XLEN-1:0]  mdu_b;
  logic                  mdu_busy;
  logic                  mdu_done;
  logic [`EXU_XLEN-1:0]  mdu_res;
  logic [`EXU_XLEN:0]    mdu_src_a;
  logic [`EXU_XLEN:0]    mdu_src_b;
  logic [`EXU_XLEN+1:0]  add_res_34;
  logic [`EXU_XLEN-1:0]  add_res_32;
  logic [`EXU_TAG_W-1:0] mdu_tag;
  logic                  is_mdu;

  // ####################
  // Issue control
  assign is_mdu    = head_op.mdu.is_mdu;
  assign head_take = head_valid && res_space && !mdu_busy && !mdu_done;  // Done cycle owns the write port.
  assign mdu_start = head_take && is_mdu;

  assign alu_a  = head_a;
  assign alu_b  = head_b;
  assign alu_op = head_op.alu.op;
  assign mdu_a  = head_a;
  assign mdu_b  = head_b;
  assign mdu_op = head_op.mdu.op;

  always_ff @(posedge clk) begin
    if (mdu_start) mdu_tag <= head_tag;
  end

  assign wr_valid = (head_take && !is_mdu) || mdu_done;
  assign wr_tag   = mdu_done ? mdu_tag : head_tag;
  assign wr_data  = mdu_done ? mdu_res : alu_c;

  exu_alu u_alu (
    .mdu_busy  (mdu_busy),
    .mdu_src_a (mdu_src_a),
    .mdu_src_b (mdu_src_b),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .alu_op    (alu_op),
    .add_res_34(add_res_34),
    .add_res_32(add_res_32),
    .not_zero  (),
    .alu_c     (alu_c)
  );

  exu_mdu u_mdu (
    .clk       (clk),
    .rst_n     (rst_n),
    .mdu_start (mdu_start),
    .mdu_op    (mdu_op),
    .mdu_a     (mdu_a),
    .mdu_b     (mdu_b),
    .add_res_34(add_res_34),
    .add_res_32(add_res_32),
    .mdu_busy  (mdu_busy),
    .mdu_src_a (mdu_src_a),
    .mdu_src_b (mdu_src_b),
    .mdu_done  (mdu_done),
    .mdu_res   (mdu_res)
  );

endmodule

`default_nettype wire

//--- exu_issue.sv
`default_nettype none
`include "exu_settings.svh"

module exu_issue (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_valid,
  input  exu_pkg::exu_op_u      req_op,
  input  logic [`EXU_XLEN-1:0]  req_a,
  input  logic [`EXU_XLEN-1:0]  req_b,
  input  logic [`EXU_TAG_W-1:0] req_tag,
  input  logic                  head_take,
  output logic                  req_credit,
  output logic                  head_valid,
  output exu_pkg::exu_op_u      head_op,
  output logic [`EXU_XLEN-1:0]  head_a,
  output logic [`EXU_XLEN-1:0]  head_b,
  output logic [`EXU_TAG_W-1:0] head_tag
);
  import exu_pkg::*;

  localparam int PTR_W = $clog2(`EXU_ISSUE_DEPTH);
  localparam int CNT_W = $clog2(`EXU_ISSUE_DEPTH + 1);

  exu_op_u               op_q  [`EXU_ISSUE_DEPTH];
  logic [`EXU_XLEN-1:0]  a_q   [`EXU_ISSUE_DEPTH];
  logic [`EXU_XLEN-1:0]  b_q   [`EXU_ISSUE_DEPTH];
  logic [`EXU_TAG_W-1:0] tag_q [`EXU_ISSUE_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;

  always_ff @(posedge clk) begin
    if (req_valid) begin  // Sender holds a credit, so a slot is free.
      op_q[wr_ptr]  <= req_op;
      a_q[wr_ptr]   <= req_a;
      b_q[wr_ptr]   <= req_b;
      tag_q[wr_ptr] <= req_tag;
    end
  end

  // Pointers wrap naturally since the depth is a power of two.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (req_valid) wr_ptr <= wr_ptr + 1'b1;
      if (head_take) rd_ptr <= rd_ptr + 1'b1;
      case ({req_valid, head_take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head_valid = (count != '0);
  assign head_op    = op_q[rd_ptr];
  assign head_a     = a_q[rd_ptr];
  assign head_b     = b_q[rd_ptr];
  assign head_tag   = tag_q[rd_ptr];
  assign req_credit = head_take;  // Freed slot goes straight back upstream.

endmodule

`default_nettype wire

//--- exu_mdu.sv
`default_nettype none
`include "exu_settings.svh"

module exu_mdu (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 mdu_start,
  input  exu_pkg::mdu_op_e     mdu_op,
  input  logic [`EXU_XLEN-1:0] mdu_a,
  input  logic [`EXU_XLEN-1:0] mdu_b,
  input  logic [`EXU_XLEN+1:0] add_res_34,
  input  logic [`EXU_XLEN-1:0] add_res_32,
  output logic                 mdu_busy,
  output logic [`EXU_XLEN:0]   mdu_src_a,
  output logic [`EXU_XLEN:0]   mdu_src_b,
  output logic                 mdu_done,
  output logic [`EXU_XLEN-1:0] mdu_res
);
  import exu_pkg::*;

  localparam int XL    = `EXU_XLEN;
  localparam int CNT_W = $clog2(`EXU_MDU_ITERS);

  mdu_op_e          op_r;
  logic [2*XL-1:0]  acc;    // Holds the product, or remainder over quotient.
  logic [XL-1:0]    opnd;   // Multiplicand or divisor.
  logic [CNT_W-1:0] cnt;
  logic [XL-1:0]    hi;
  logic [XL-1:0]    lo;
  logic [XL-1:0]    rem_sh;
  logic             is_div;
  logic             carry;
  logic             q_bit;

  assign hi     = acc[2*XL-1:XL];
  assign lo     = acc[XL-1:0];
  assign is_div = (op_r == DIVU) || (op_r == REMU);
  assign rem_sh = {hi[XL-2:0], lo[XL-1]};
  assign carry  = add_res_34[XL+1];
  assign q_bit  = carry | hi[XL-1];  // Shifted-out MSB means the subtract always fits.

  always_comb begin
    if (is_div) begin
      mdu_src_a = {rem_sh, 1'b1};
      mdu_src_b = ~{opnd, 1'b0};
    end else begin
      mdu_src_a = {hi, 1'b0};
      mdu_src_b = {opnd & {XL{lo[0]}}, 1'b0};
    end
  end

  // A zero divisor gives all-ones quotient and remainder equal to the dividend.
  always_ff @(posedge clk) begin
    if (mdu_start) begin
      op_r <= mdu_op;
      opnd <= mdu_b;
      acc  <= {{XL{1'b0}}, mdu_a};
    end else if (mdu_busy) begin
      if (is_div) begin
        acc <= {(q_bit ? add_res_32 : rem_sh), lo[XL-2:0], q_bit};
      end else begin
        acc <= {carry, add_res_32, lo[XL-1:1]};
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mdu_busy <= 1'b0;
      mdu_done <= 1'b0;
      cnt      <= '0;
    end else begin
      mdu_done <= 1'b0;
      if (mdu_start) begin
        mdu_busy <= 1'b1;
        cnt      <= '0;
      end else if (mdu_busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == CNT_W'(`EXU_MDU_ITERS - 1)) begin  // Last iteration.
          mdu_busy <= 1'b0;
          mdu_done <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    case (op_r)
      MUL:     mdu_res = lo;
      MULHU:   mdu_res = hi;
      DIVU:    mdu_res = lo;
      default: mdu_res = hi;
    endcase
  end

endmodule

`default_nettype wire

//--- exu_pkg.sv
`default_nettype none

package exu_pkg;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    EQ,
    NE,
    LT,
    LTU,
    GE,
    GEU,
    SLL,
    SRL,
    SRA,
    AND,
    OR,
    XOR
  } alu_op_e;

  typedef enum logic [1:0] {
    MUL,    // Low word of product.
    MULHU,  // High word of product.
    DIVU,
    REMU
  } mdu_op_e;

  // The is_mdu bit picks the view of the operation word.
  typedef union packed {
    struct packed {
      logic    is_mdu;
      alu_op_e op;
    } alu;
    struct packed {
      logic       is_mdu;
      logic [1:0] pad;
      mdu_op_e    op;
    } mdu;
  } exu_op_u;

endpackage

`default_nettype wire

//--- exu_result.sv
`default_nettype none
`include "exu_settings.svh"

module exu_result (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_valid,
  input  logic [`EXU_TAG_W-1:0] wr_tag,
  input  logic [`EXU_XLEN-1:0]  wr_data,
  input  logic                  res_credit,
  output logic                  res_space,
  output logic                  res_valid,
  output logic [`EXU_TAG_W-1:0] res_tag,
  output logic [`EXU_XLEN-1:0]  res_data
);

  localparam int PTR_W = $clog2(`EXU_RESULT_DEPTH);
  localparam int CNT_W = $clog2(`EXU_RESULT_DEPTH + 1);
  localparam int CRD_W = $clog2(`EXU_OUT_CREDITS + 1);

  logic [`EXU_TAG_W-1:0] tag_q  [`EXU_RESULT_DEPTH];
  logic [`EXU_XLEN-1:0]  data_q [`EXU_RESULT_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic [CRD_W-1:0]      credits;

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      tag_q[wr_ptr]  <= wr_tag;
      data_q[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CRD_W'(`EXU_OUT_CREDITS);
    end else begin
      if (wr_valid)  wr_ptr <= wr_ptr + 1'b1;
      if (res_valid) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_valid, res_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      case ({res_valid, res_credit})  // Send and return together cancel out.
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  assign res_space = (count != CNT_W'(`EXU_RESULT_DEPTH));
  assign res_valid = (count != '0) && (credits != '0);
  assign res_tag   = tag_q[rd_ptr];
  assign res_data  = data_q[rd_ptr];

endmodule

`default_nettype wire

//--- exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// Datapath and request tag widths.
`define EXU_XLEN 32
`define EXU_TAG_W 4

// Issue depth doubles as the number of upstream credits.
`define EXU_ISSUE_DEPTH 4
`define EXU_RESULT_DEPTH 4
`define EXU_OUT_CREDITS 2

// One MDU iteration per operand bit.
`define EXU_MDU_ITERS 32

`endif

//--- exu_tb.sv
`default_nettype none
`include "exu_settings.svh"

module exu_tb;
  import exu_pkg::*;

  typedef logic [`EXU_XLEN-1:0] word_t;
  typedef logic [`EXU_TAG_W+`EXU_XLEN-1:0] entry_t;

  localparam int SEND_LIMIT  = 1000;
  localparam int DRAIN_LIMIT = 5000;

  logic                  clk;
  logic                  rst_n;
  logic                  req_valid;
  exu_op_u               req_op;
  word_t                 req_a;
  word_t                 req_b;
  logic [`EXU_TAG_W-1:0] req_tag;
  logic                  req_credit;
  logic                  res_valid;
  logic [`EXU_TAG_W-1:0] res_tag;
  word_t                 res_data;
  logic                  res_credit;

  integer                seed = 32'hbce71081;
  integer                credit_seed = 32'hbce71081;
  entry_t                exp_q[$];
  entry_t                exp_item;
  logic [`EXU_TAG_W-1:0] next_tag = '0;
  int up_credits   = `EXU_ISSUE_DEPTH;
  int granted      = `EXU_OUT_CREDITS;  // Downstream credits handed to the DUT so far.
  int used         = 0;                 // Results received.
  int returned     = 0;                 // Credit pulses driven.
  int sent         = 0;
  int hold_left    = 0;
  int value_errors = 0;
  int other_errors = 0;
  bit started      = 1'b0;
  bit timed_out    = 1'b0;

  exu_top uut (
    .clk(clk), .rst_n(rst_n),
    .req_valid(req_valid), .req_op(req_op), .req_a(req_a), .req_b(req_b),
    .req_tag(req_tag), .req_credit(req_credit),
    .res_valid(res_valid), .res_tag(res_tag), .res_data(res_data), .res_credit(res_credit)
  );

  always #5 clk = ~clk;

  // ####################
  // Reference model
  function automatic word_t model_result(input exu_op_u op, input word_t a, input word_t b);
    logic [2*`EXU_XLEN-1:0] prod;
    logic [4:0]             sh;
    prod = {{`EXU_XLEN{1'b0}}, a} * {{`EXU_XLEN{1'b0}}, b};
    sh   = b[4:0];
    if (op.mdu.is_mdu) begin
      case (op.mdu.op)
        MUL:     return prod[`EXU_XLEN-1:0];
        MULHU:   return prod[2*`EXU_XLEN-1:`EXU_XLEN];
        DIVU:    return (b == '0) ? '1 : a / b;
        default: return (b == '0) ? a : a % b;  // RISC-V rule for a zero divisor.
      endcase
    end
    case (op.alu.op)
      SUB:     return a - b;
      EQ:      return word_t'(a == b);
      NE:      return word_t'(a != b);
      LT:      return word_t'($signed(a) < $signed(b));
      LTU:     return word_t'(a < b);
      GE:      return word_t'($signed(a) >= $signed(b));
      GEU:     return word_t'(a >= b);
      SLL:     return a << sh;
      SRL:     return a >> sh;
      SRA:     return $signed(a) >>> sh;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      default: return a + b;
    endcase
  endfunction

  function automatic exu_op_u alu_word(input int n);
    exu_op_u w;
    w            = '0;
    w.alu.is_mdu = 1'b0;
    w.alu.op     = alu_op_e'(n);
    return w;
  endfunction

  function automatic exu_op_u mdu_word(input int n);
    exu_op_u w;
    w            = '0;
    w.mdu.is_mdu = 1'b1;
    w.mdu.op     = mdu_op_e'(n);
    return w;
  endfunction

  function automatic word_t pick_operand(input int sel, input word_t r);
    case (sel)
      0:       return '0;
      1:       return 32'h0000_0001;
      2:       return 32'h7fff_ffff;  // Sign boundaries.
      3:       return 32'h8000_0000;
      4:       return '1;
      5:       return 32'h0000_001f;  // Largest shift amount.
      default: return r;
    endcase
  endfunction

  task automatic finish_run();
    $display("Closing: %0d value errors, %0d other errors, %0d results checked",
             value_errors, other_errors, used);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  // ####################
  // Stimulus
  task automatic send_op(input exu_op_u op, input word_t a, input word_t b);
    int t;
    t = 0;
    if (timed_out) return;
    @(posedge clk);
    req_valid <= 1'b0;
    while (up_credits == 0 && t < SEND_LIMIT) begin
      @(posedge clk);
      req_valid <= 1'b0;
      t++;
    end
    if (up_credits == 0) begin
      other_errors++;
      $display("No upstream credit came back within %0d cycles at %0t", SEND_LIMIT, $time);
      timed_out = 1'b1;
    end else begin
      req_valid <= 1'b1;
      req_op    <= op;
      req_a     <= a;
      req_b     <= b;
      req_tag   <= next_tag;
      up_credits--;
      started = 1'b1;
      sent++;
      exp_q.push_back({next_tag, model_result(op, a, b)});
      next_tag++;
    end
  endtask

  // Kind 0 is ALU, 1 multiply, 2 divide, 3 a mix of all.
  task automatic send_random(input int kind);
    exu_op_u op;
    word_t   a;
    word_t   b;
    int      k;
    k = (kind == 3) ? $unsigned($random(seed)) % 3 : kind;
    case (k)
      0:       op = alu_word($unsigned($random(seed)) % 14);
      1:       op = mdu_word($unsigned($random(seed)) % 2);
      default: op = mdu_word(2 + $unsigned($random(seed)) % 2);
    endcase
    a = pick_operand($unsigned($random(seed)) % 12, $random(seed));
    b = pick_operand($unsigned($random(seed)) % 12, $random(seed));
    if ($unsigned($random(seed)) % 8 == 0) b = a;
    send_op(op, a, b);
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_q.size() != 0 && !timed_out && t < DRAIN_LIMIT) begin
      @(posedge clk);
      req_valid <= 1'b0;
      t++;
    end
    if (exp_q.size() != 0 && !timed_out) begin
      other_errors++;
      $display("%0d results still missing after %0d cycles", exp_q.size(), DRAIN_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  // Returns credits only for results already received.
  always @(posedge clk) begin
    res_credit <= 1'b0;
    if (hold_left > 0) begin
      hold_left--;
    end else if (rst_n && returned < used && $random(credit_seed) % 2 == 0) begin
      res_credit <= 1'b1;
      returned++;
    end
  end

  // ####################
  // Monitor
  always @(negedge clk) begin
    if (!started) begin
      assert (!res_valid && !req_credit) else begin
        other_errors++;
        $display("Output activity before the first request at %0t", $time);
      end
    end
    if (req_credit) up_credits++;
    if (res_valid) begin
      assert (used < granted) else begin
        other_errors++;
        $display("Result sent without a downstream credit at %0t", $time);
      end
      used++;
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("Result with no matching request at %0t", $time);
      end else begin
        exp_item = exp_q.pop_front();
        assert (res_tag === exp_item[`EXU_TAG_W+`EXU_XLEN-1:`EXU_XLEN]) else begin
          value_errors++;
          $display("CHECK FAILED at %0t: res_tag expected %h, got %h", $time,
                   exp_item[`EXU_TAG_W+`EXU_XLEN-1:`EXU_XLEN], res_tag);
        end
        assert (res_data === exp_item[`EXU_XLEN-1:0]) else begin
          value_errors++;
          $display("CHECK FAILED at %0t: res_data expected %h, got %h", $time,
                   exp_item[`EXU_XLEN-1:0], res_data);
        end
      end
    end
    if (res_credit) granted++;
  end

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_op     = '0;
    req_a      = '0;
    req_b      = '0;
    req_tag    = '0;
    res_credit = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (6) @(posedge clk);  // Quiet cycles after reset.
    repeat (60) send_random(0);
    repeat (30) send_random(1);
    repeat (30) send_random(2);
    repeat (80) send_random(3);
    repeat (3) begin
      @(negedge clk);
      hold_left = 150;  // Long stall downstream.
      repeat (16) send_random(3);
    end
    wait_drain();
    if (!timed_out) begin
      repeat (20) begin
        @(posedge clk);
        req_valid <= 1'b0;
      end
      assert (up_credits == `EXU_ISSUE_DEPTH) else begin
        other_errors++;
        $display("Upstream credits not all returned, %0d of %0d", up_credits, `EXU_ISSUE_DEPTH);
      end
      assert (used == sent) else begin
        other_errors++;
        $display("Received %0d results for %0d requests", used, sent);
      end
    end
    finish_run();
  end

endmodule

`default_nettype wire

//--- exu_top.sv
`default_nettype none
`include "exu_settings.svh"

module exu_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_valid,
  input  exu_pkg::exu_op_u      req_op,
  input  logic [`EXU_XLEN-1:0]  req_a,
  input  logic [`EXU_XLEN-1:0]  req_b,
  input  logic [`EXU_TAG_W-1:0] req_tag,
  output logic                  req_credit,
  output logic                  res_valid,
  output logic [`EXU_TAG_W-1:0] res_tag,
  output logic [`EXU_XLEN-1:0]  res_data,
  input  logic                  res_credit
);
  import exu_pkg::*;

  logic                  head_valid;
  exu_op_u               head_op;
  logic [`EXU_XLEN-1:0]  head_a;
  logic [`EXU_XLEN-1:0]  head_b;
  logic [`EXU_TAG_W-1:0] head_tag;
  logic                  head_take;
  logic                  res_space;
  logic                  wr_valid;
  logic [`EXU_TAG_W-1:0] wr_tag;
  logic [`EXU_XLEN-1:0]  wr_data;

  exu_issue u_issue (
    .clk(clk), .rst_n(rst_n),
    .req_valid(req_valid), .req_op(req_op), .req_a(req_a), .req_b(req_b),
    .req_tag(req_tag), .head_take(head_take), .req_credit(req_credit),
    .head_valid(head_valid), .head_op(head_op), .head_a(head_a),
    .head_b(head_b), .head_tag(head_tag)
  );

  exu_core u_core (
    .clk(clk), .rst_n(rst_n),
    .head_valid(head_valid), .head_op(head_op), .head_a(head_a),
    .head_b(head_b), .head_tag(head_tag), .res_space(res_space),
    .head_take(head_take), .wr_valid(wr_valid), .wr_tag(wr_tag), .wr_data(wr_data)
  );

  exu_result u_result (
    .clk(clk), .rst_n(rst_n),
    .wr_valid(wr_valid), .wr_tag(wr_tag), .wr_data(wr_data), .res_credit(res_credit),
    .res_space(res_space), .res_valid(res_valid), .res_tag(res_tag), .res_data(res_data)
  );

endmodule

`default_nettype wire

//--- src.f
+incdir+.
exu_pkg.sv
exu_issue.sv
exu_alu.sv
exu_mdu.sv
exu_core.sv
exu_result.sv
exu_top.sv
exu_tb.sv
